//--- Bender.yml
package:
  name: sprite_engine

sources:
  - sprite_pkg.sv
  - sprite_list_copy.sv
  - sprite_pixel_fetch.sv
  - sprite_line_draw.sv
  - sprite_engine.sv
  - target: test
    files:
      - sprite_engine_asserts.sv
      - tb_sprite_engine.sv

//--- sprite_engine.sv
// sprite engine top, joins the list copy, line drawer and pixel fetch
`timescale 1ns/1ps

module sprite_engine
    import sprite_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  list_wr,
    input  logic [7:0]            list_addr,
    input  logic [7:0]            list_data,
    input  logic                  bank_wr,
    input  logic [7:0]            bank_addr,
    input  logic [3:0]            bank_data,
    input  logic                  board_later,
    input  logic                  vblank,
    input  logic [8:0]            hpos,
    input  logic [8:0]            vpos,
    output logic [GFX_ADDR_W-1:0] gfx_addr,
    input  logic [7:0]            gfx_data,
    output logic                  copy_busy,
    output logic                  line_busy,
    output logic [SPR_PIX_W-1:0]  sprite_pix
);

    logic [SPRITE_IDX_W-1:0] buf_rd_idx;
    logic [ENTRY_W-1:0]      buf_rd_data;
    logic [TILE_W-1:0]       tile;
    logic [3:0]              colour;
    logic                    flip_x;
    logic                    flip_y;
    logic [3:0]              x_ofs;
    logic [3:0]              y_ofs;
    logic [SPR_PIX_W-1:0]    spr_pix;
    logic                    pix_opaque;

    // list memory and sprite buffer, busy during vblank
    sprite_list_copy i_copy (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .board_later (board_later),
        .vblank      (vblank),
        .list_wr     (list_wr),
        .list_addr   (list_addr),
        .list_data   (list_data),
        .buf_rd_idx  (buf_rd_idx),
        .buf_rd_data (buf_rd_data),
        .copy_busy   (copy_busy)
    );

    sprite_line_draw i_draw (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .hpos        (hpos),
        .vpos        (vpos),
        .buf_rd_data (buf_rd_data),
        .spr_pix     (spr_pix),
        .pix_opaque  (pix_opaque),
        .buf_rd_idx  (buf_rd_idx),
        .tile        (tile),
        .colour      (colour),
        .flip_x      (flip_x),
        .flip_y      (flip_y),
        .x_ofs       (x_ofs),
        .y_ofs       (y_ofs),
        .line_busy   (line_busy),
        .sprite_pix  (sprite_pix)
    );

    sprite_pixel_fetch i_fetch (
        .clk_sys     (clk_sys),
        .board_later (board_later),
        .bank_wr     (bank_wr),
        .bank_addr   (bank_addr),
        .bank_data   (bank_data),
        .tile        (tile),
        .colour      (colour),
        .flip_x      (flip_x),
        .flip_y      (flip_y),
        .x_ofs       (x_ofs),
        .y_ofs       (y_ofs),
        .gfx_data    (gfx_data),
        .gfx_addr    (gfx_addr),
        .spr_pix     (spr_pix),
        .pix_opaque  (pix_opaque)
    );

endmodule

//--- sprite_engine_asserts.sv
// concurrent checks on the line drawer, bound into every sprite_line_draw instance
`timescale 1ns/1ps

module sprite_engine_asserts
    import sprite_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic [8:0] hpos,
    input  logic [2:0] draw_state,
    input  logic       line_busy,
    input  logic       pix_wr,
    input  logic [8:0] pix_x
);

    // drawer comes out of reset idle
    a_idle_after_reset: assert property (@(posedge clk_sys) reset |=> !line_busy)
        else $error("line_busy high one clock after reset");

    // pixel writes stay on the visible line
    a_pix_on_line: assert property (@(posedge clk_sys) disable iff (reset)
        pix_wr |-> (pix_x < 9'(LINE_WIDTH)))
        else $error("line buffer written past the line end");

    // a new line only starts in the horizontal blank
    a_start_in_hblank: assert property (@(posedge clk_sys) disable iff (reset)
        ((draw_state == DRAW_IDLE) && (hpos < 9'(LINE_WIDTH))) |=> (draw_state == DRAW_IDLE))
        else $error("drawer left idle during the visible line");

endmodule

bind sprite_line_draw sprite_engine_asserts i_asserts (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .hpos       (hpos),
    .draw_state (draw_state),
    .line_busy  (line_busy),
    .pix_wr     (pix_wr),
    .pix_x      (pix_x)
);

//--- sprite_line_draw.sv
// per-line sprite drawer into the line buffer, plus the registered pixel readout
`timescale 1ns/1ps

module sprite_line_draw
    import sprite_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    reset,
    input  logic [8:0]              hpos,
    input  logic [8:0]              vpos,
    input  logic [ENTRY_W-1:0]      buf_rd_data,
    input  logic [SPR_PIX_W-1:0]    spr_pix,
    input  logic                    pix_opaque,
    output logic [SPRITE_IDX_W-1:0] buf_rd_idx,
    output logic [TILE_W-1:0]       tile,
    output logic [3:0]              colour,
    output logic                    flip_x,
    output logic                    flip_y,
    output logic [3:0]              x_ofs,
    output logic [3:0]              y_ofs,
    output logic                    line_busy,
    output logic [SPR_PIX_W-1:0]    sprite_pix
);

    logic [2:0]           draw_state;
    logic [7:0]           clr_cnt;
    logic [8:0]           next_line;
    logic [8:0]           line_tgt;
    logic [8:0]           line_diff;
    logic [8:0]           spr_x;
    logic [7:0]           spr_y;
    logic                 sprite_hit;
    logic                 last_col;
    logic                 sprite_end;
    logic                 pix_wr;
    logic [8:0]           pix_x;

    logic [SPR_PIX_W-1:0] line_buf [LINE_WIDTH];
    logic                 lb_we;
    logic [7:0]           lb_waddr;
    logic [SPR_PIX_W-1:0] lb_wdata;

    // ======================================================================
    // sprite geometry against the target line
    // ======================================================================
    assign next_line  = vpos + 9'd1;
    assign line_diff  = line_tgt - {1'b0, spr_y};
    assign y_ofs      = line_diff[3:0];
    // sprites at x 256 and up are off the line entirely
    assign sprite_hit = !spr_x[8] && (line_tgt >= {1'b0, spr_y})
                        && (line_diff < 9'(SPRITE_SIZE));

    assign pix_x      = spr_x + {5'd0, x_ofs};
    // stop at column 15 or at the right edge of the line
    assign last_col   = (x_ofs == 4'd15) || (pix_x == 9'(LINE_WIDTH - 1));
    assign pix_wr     = (draw_state == DRAW_WRITE) && pix_opaque;
    assign sprite_end = ((draw_state == DRAW_WRITE) && last_col)
                        || (draw_state == DRAW_SKIP);

    assign line_busy  = (draw_state != DRAW_IDLE) && (draw_state != DRAW_DONE);

    // ======================================================================
    // drawer FSM
    // ======================================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            draw_state <= DRAW_IDLE;
            clr_cnt    <= '0;
            buf_rd_idx <= '0;
            x_ofs      <= '0;
        end else begin
            case (draw_state)
                DRAW_IDLE: begin
                    if ((hpos >= 9'(LINE_WIDTH)) && (next_line >= 9'(SPRITE_SIZE))) begin
                        draw_state <= DRAW_CLEAR;
                        clr_cnt    <= '0;
                        buf_rd_idx <= '0;
                    end
                end
                DRAW_CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == 8'd255) begin
                        draw_state <= DRAW_READ;
                    end
                end
                // buffer read address held one clock
                DRAW_READ: draw_state <= DRAW_LATCH;
                DRAW_LATCH: begin
                    x_ofs      <= '0;
                    draw_state <= DRAW_FETCH;
                end
                // rom address out here, data back in the write state
                DRAW_FETCH: draw_state <= sprite_hit ? DRAW_WRITE : DRAW_SKIP;
                DRAW_WRITE: begin
                    if (!last_col) begin
                        x_ofs      <= x_ofs + 1'b1;
                        draw_state <= DRAW_FETCH;
                    end
                end
                DRAW_DONE: begin
                    if (hpos == 9'd0) begin
                        draw_state <= DRAW_IDLE;
                    end
                end
                default: ;
            endcase

            // next list entry or end of line
            if (sprite_end) begin
                if (buf_rd_idx == SPRITE_IDX_W'(SPRITE_COUNT - 1)) begin
                    draw_state <= DRAW_DONE;
                end else begin
                    buf_rd_idx <= buf_rd_idx + 1'b1;
                    draw_state <= DRAW_READ;
                end
            end
        end
    end

    // target line and entry fields
    always_ff @(posedge clk_sys) begin
        if (draw_state == DRAW_IDLE) begin
            line_tgt <= next_line;
        end
        if (draw_state == DRAW_LATCH) begin
            {tile, spr_x, spr_y, colour, flip_x, flip_y} <= buf_rd_data;
        end
    end

    // ======================================================================
    // line buffer
    // ======================================================================
    assign lb_we    = (draw_state == DRAW_CLEAR) || pix_wr;
    assign lb_waddr = (draw_state == DRAW_CLEAR) ? clr_cnt : pix_x[7:0];
    assign lb_wdata = (draw_state == DRAW_CLEAR) ? '0 : spr_pix;

    always_ff @(posedge clk_sys) begin
        if (lb_we) begin
            line_buf[lb_waddr] <= lb_wdata;
        end
        // readout during the visible part of the line
        if (hpos < 9'(LINE_WIDTH)) begin
            sprite_pix <= line_buf[hpos[7:0]];
        end
    end

endmodule

//--- sprite_list_copy.sv
// sprite list memory and sprite buffer, decodes the whole list at each vertical blank start
`timescale 1ns/1ps

module sprite_list_copy
    import sprite_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    reset,
    input  logic                    board_later,
    input  logic                    vblank,
    input  logic                    list_wr,
    input  logic [7:0]              list_addr,
    input  logic [7:0]              list_data,
    input  logic [SPRITE_IDX_W-1:0] buf_rd_idx,
    output logic [ENTRY_W-1:0]      buf_rd_data,
    output logic                    copy_busy
);

    logic [7:0]              list_mem [LIST_BYTES];
    logic [7:0]              list_q;
    logic [7:0]              list_rd_addr;
    logic [ENTRY_W-1:0]      buf_mem [SPRITE_COUNT];
    logic                    buf_wr;
    logic [ENTRY_W-1:0]      buf_din;

    logic [1:0]              vbl_sr;
    logic                    vbl_rise;
    logic [2:0]              copy_step;
    logic [SPRITE_IDX_W-1:0] copy_idx;

    sprite_attr_u            attr;
    logic [TILE_W-1:0]       cp_tile;
    logic [8:0]              cp_x;
    logic [7:0]              cp_y;
    logic [3:0]              cp_colour;
    logic                    cp_x_hi;
    logic                    cp_flip_x;
    logic                    cp_flip_y;

    // ======================================================================
    // list memory, cpu write side and copy read side
    // ======================================================================
    // steps 0..3 walk the four bytes of the current entry
    assign list_rd_addr = {copy_idx, copy_step[1:0]};

    always_ff @(posedge clk_sys) begin
        if (list_wr) begin
            list_mem[list_addr] <= list_data;
        end
        list_q <= list_mem[list_rd_addr];
    end

    // vblank rising edge, acted on two clocks after the input rises
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vbl_sr <= 2'b00;
        end else begin
            vbl_sr <= {vbl_sr[0], vblank};
        end
    end

    assign vbl_rise = (vbl_sr == 2'b01);

    // ======================================================================
    // copy sequencer
    // ======================================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            copy_busy <= 1'b0;
            copy_step <= '0;
            copy_idx  <= '0;
            buf_wr    <= 1'b0;
        end else if (!copy_busy) begin
            buf_wr <= 1'b0;
            if (vbl_rise) begin
                copy_busy <= 1'b1;
                copy_step <= '0;
                copy_idx  <= '0;
            end
        end else begin
            // buffer write lands in the last step of the entry
            buf_wr <= (copy_step == 3'd5);
            if (copy_step == 3'(COPY_LAST_STEP)) begin
                copy_step <= '0;
                copy_idx  <= copy_idx + 1'b1;
                if (copy_idx == SPRITE_IDX_W'(SPRITE_COUNT - 1)) begin
                    copy_busy <= 1'b0;
                end
            end else begin
                copy_step <= copy_step + 1'b1;
            end
        end
    end

    // list data arrives one step after its address
    assign attr = list_q;

    always_ff @(posedge clk_sys) begin
        if (copy_busy) begin
            case (copy_step)
                3'd1: cp_y <= Y_BASE - list_q;
                3'd2: cp_tile[7:0] <= list_q;
                3'd3: begin
                    if (board_later) begin
                        cp_x_hi      <= attr.later.x_hi;
                        cp_tile[9:8] <= {attr.later.tile_9, attr.later.tile_8};
                        cp_flip_x    <= attr.later.flip_x;
                        cp_flip_y    <= attr.later.flip_y;
                        cp_colour    <= {attr.later.colour_hi, 1'b0};
                    end else begin
                        cp_x_hi      <= attr.orig.x_hi;
                        cp_tile[9:8] <= {1'b0, attr.orig.tile_8};
                        cp_flip_x    <= attr.orig.flip_x;
                        cp_flip_y    <= attr.orig.flip_y;
                        cp_colour    <= attr.orig.colour;
                    end
                end
                // 9-bit screen x wraps like the board
                3'd4: cp_x <= {cp_x_hi, list_q} - X_BIAS;
                default: ;
            endcase
        end
    end

    // ======================================================================
    // sprite buffer
    // ======================================================================
    assign buf_din = {cp_tile, cp_x, cp_y, cp_colour, cp_flip_x, cp_flip_y};

    always_ff @(posedge clk_sys) begin
        if (buf_wr) begin
            buf_mem[copy_idx] <= buf_din;
        end
        buf_rd_data <= buf_mem[buf_rd_idx];
    end

endmodule

//--- sprite_pixel_fetch.sv
// graphics rom addressing and sprite pixel build with the palette bank prom
`timescale 1ns/1ps

module sprite_pixel_fetch
    import sprite_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  board_later,
    input  logic                  bank_wr,
    input  logic [7:0]            bank_addr,
    input  logic [3:0]            bank_data,
    input  logic [TILE_W-1:0]     tile,
    input  logic [3:0]            colour,
    input  logic                  flip_x,
    input  logic                  flip_y,
    input  logic [3:0]            x_ofs,
    input  logic [3:0]            y_ofs,
    input  logic [7:0]            gfx_data,
    output logic [GFX_ADDR_W-1:0] gfx_addr,
    output logic [SPR_PIX_W-1:0]  spr_pix,
    output logic                  pix_opaque
);

    logic [3:0] bank_prom [256];
    logic [7:0] bank_idx;
    logic [3:0] bank;
    logic [3:0] fx;
    logic [3:0] fy;
    logic [3:0] pen;
    logic [3:0] pen_clear;
    logic [3:0] pix_colour;

    // palette bank prom load
    always_ff @(posedge clk_sys) begin
        if (bank_wr) begin
            bank_prom[bank_addr] <= bank_data;
        end
    end

    // mirrored offsets inside the 16x16 cell
    assign fx = flip_x ? (4'd15 - x_ofs) : x_ofs;
    assign fy = flip_y ? (4'd15 - y_ofs) : y_ofs;

    // two pens per rom byte, odd mirrored column in the high nibble
    assign pen = fx[0] ? gfx_data[7:4] : gfx_data[3:0];

    always_comb begin
        if (board_later) begin
            gfx_addr   = {fx[1], tile[9:0], fy, fx[3:2]};
            bank_idx   = {tile[9], tile[7:2], tile[8]};
            pix_colour = {colour[3:1], 1'b0};
            pen_clear  = PEN_CLEAR_LATER;
        end else begin
            // 512 tiles only, top address bit unused
            gfx_addr   = {1'b0, fx[1], tile[8:0], fy, fx[3:2]};
            bank_idx   = tile[8:1];
            pix_colour = colour;
            pen_clear  = PEN_CLEAR_ORIG;
        end
    end

    assign bank       = bank_prom[bank_idx];
    assign spr_pix    = {bank, pix_colour, pen};
    assign pix_opaque = (pen != pen_clear);

endmodule

//--- sprite_pkg.sv
// shared sprite engine constants, drawer state codes and the list attribute byte views
package sprite_pkg;

    // ======================================================================
    // geometry
    // ======================================================================
    localparam int SPRITE_COUNT = 64;
    localparam int SPRITE_IDX_W = 6;
    localparam int LIST_BYTES   = 256;
    localparam int LINE_WIDTH   = 256;
    localparam int SPRITE_SIZE  = 16;

    // list y byte counts up from the bottom of the screen
    localparam logic [7:0] Y_BASE = 8'd240;
    localparam logic [7:0] X_BIAS = 8'd128;

    // ======================================================================
    // word widths
    // ======================================================================
    localparam int TILE_W     = 10;
    // bank, colour, pen
    localparam int SPR_PIX_W  = 12;
    // tile, x, y, colour, flip x, flip y
    localparam int ENTRY_W    = 33;
    localparam int GFX_ADDR_W = 17;

    // transparent pens per board
    localparam logic [3:0] PEN_CLEAR_ORIG  = 4'd0;
    localparam logic [3:0] PEN_CLEAR_LATER = 4'd15;

    // copy sequencer runs steps 0 to 6 per list entry
    localparam int COPY_LAST_STEP = 6;

    // ======================================================================
    // line drawer states
    // ======================================================================
    localparam logic [2:0] DRAW_IDLE  = 3'd0;
    localparam logic [2:0] DRAW_CLEAR = 3'd1;
    localparam logic [2:0] DRAW_READ  = 3'd2;
    localparam logic [2:0] DRAW_LATCH = 3'd3;
    localparam logic [2:0] DRAW_FETCH = 3'd4;
    localparam logic [2:0] DRAW_WRITE = 3'd5;
    localparam logic [2:0] DRAW_SKIP  = 3'd6;
    localparam logic [2:0] DRAW_DONE  = 3'd7;

    // third list byte, decoded differently on the two boards
    typedef union packed {
        struct packed {
            logic [3:0] colour;
            logic       flip_y;
            logic       flip_x;
            logic       tile_8;
            logic       x_hi;
        } orig;
        struct packed {
            logic [2:0] colour_hi;
            logic       tile_8;
            logic       flip_y;
            logic       flip_x;
            logic       tile_9;
            logic       x_hi;
        } later;
    } sprite_attr_u;

endpackage

//--- tb.f
sprite_pkg.sv
sprite_list_copy.sv
sprite_pixel_fetch.sv
sprite_line_draw.sv
sprite_engine.sv
sprite_engine_asserts.sv
tb_sprite_engine.sv

//--- tb_sprite_engine.sv
// testbench for the sprite engine that runs a table of list and line tests against a pixel model
`timescale 1ns/1ps

module tb_sprite_engine
    import sprite_pkg::*;
();

    localparam int NUM_TESTS = 11;

    // how the sprite list of a row is built
    localparam logic [2:0] MODE_SINGLE  = 3'd0;
    localparam logic [2:0] MODE_FLIP    = 3'd1;
    localparam logic [2:0] MODE_OVERLAP = 3'd2;
    localparam logic [2:0] MODE_EDGE    = 3'd3;
    localparam logic [2:0] MODE_LCG     = 3'd4;

    typedef struct packed {
        logic       later;
        logic [6:0] count;
        logic [2:0] mode;
        logic [8:0] vpos;
    } row_t;

    logic                  clk_sys;
    logic                  reset;
    logic                  list_wr;
    logic [7:0]            list_addr;
    logic [7:0]            list_data;
    logic                  bank_wr;
    logic [7:0]            bank_addr;
    logic [3:0]            bank_data;
    logic                  board_later;
    logic                  vblank;
    logic [8:0]            hpos;
    logic [8:0]            vpos;
    logic [GFX_ADDR_W-1:0] gfx_addr;
    logic [7:0]            gfx_data;
    logic                  copy_busy;
    logic                  line_busy;
    logic [SPR_PIX_W-1:0]  sprite_pix;

    row_t                  rows [NUM_TESTS];
    logic [7:0]            list_bytes [256];
    logic [3:0]            bank_model [256];
    logic [SPR_PIX_W-1:0]  exp_line [256];
    logic [31:0]           lcg_state;
    int                    errors;
    int                    test_errors;
    logic                  timed_out;

    sprite_engine i_dut (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .list_wr     (list_wr),
        .list_addr   (list_addr),
        .list_data   (list_data),
        .bank_wr     (bank_wr),
        .bank_addr   (bank_addr),
        .bank_data   (bank_data),
        .board_later (board_later),
        .vblank      (vblank),
        .hpos        (hpos),
        .vpos        (vpos),
        .gfx_addr    (gfx_addr),
        .gfx_data    (gfx_data),
        .copy_busy   (copy_busy),
        .line_busy   (line_busy),
        .sprite_pix  (sprite_pix)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // ======================================================================
    // graphics rom model and helpers
    // ======================================================================
    function automatic logic [7:0] rom_byte(input logic [16:0] a);
        logic [31:0] m;
        m = {15'd0, a} * 32'h2545_f491;
        return m[31:24] ^ m[15:8] ^ a[7:0];
    endfunction

    // registered read one clock behind the address
    initial begin
        gfx_data = '0;
        forever begin
            @(posedge clk_sys);
            gfx_data <= rom_byte(gfx_addr);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    // which selects copy_busy with 0 and line_busy with 1
    task automatic wait_level(input int which, input logic level, input int limit,
                              input string what);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk_sys);
            if (((which == 0) ? copy_busy : line_busy) === level) begin
                done = 1'b1;
            end else begin
                n++;
                if (n >= limit) begin
                    $display("timeout: %s did not happen within %0d clocks", what, limit);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    // ======================================================================
    // list building from screen coordinates
    // ======================================================================
    task automatic put_sprite(input int s, input int x, input int y, input logic [9:0] tile,
                              input logic [3:0] colour, input logic fx, input logic fy,
                              input logic later);
        logic [8:0] x9;
        logic [7:0] y8;
        x9 = 9'(x + 128);
        y8 = 8'(y);
        list_bytes[4*s]   = 8'd240 - y8;
        list_bytes[4*s+1] = tile[7:0];
        if (later) begin
            list_bytes[4*s+2] = {colour[3:1], tile[8], fy, fx, tile[9], x9[8]};
        end else begin
            list_bytes[4*s+2] = {colour, fy, fx, tile[8], x9[8]};
        end
        list_bytes[4*s+3] = x9[7:0];
    endtask

    task automatic build_list(input logic [2:0] mode, input int count, input logic later,
                              input int line);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int s = 0; s < 64; s++) begin
            if (s >= count) begin
                // parked at screen x 256 where it is never drawn
                put_sprite(s, 256, 0, 10'd0, 4'd0, 1'b0, 1'b0, later);
            end else begin
                case (mode)
                    MODE_SINGLE: put_sprite(s, 40, line - 5, 10'h123, 4'ha, 1'b0, 1'b0, later);
                    MODE_FLIP: put_sprite(s, 20 + 48 * s, line - 1 - 3 * s,
                                          10'(10'h2c5 ^ (s * 77)), 4'(3 + 3 * s),
                                          s[0], s[1], later);
                    MODE_OVERLAP: put_sprite(s, 50 + 3 * s, line - 2 * s, 10'(64 + 9 * s),
                                             4'(2 * s + 1), s[1], s[0], later);
                    MODE_EDGE: begin
                        case (s)
                            0: put_sprite(s, 250, line - 2, 10'h011, 4'd5, 1'b0, 1'b0, later);
                            1: put_sprite(s, 255, line - 7, 10'h0f0, 4'd6, 1'b1, 1'b0, later);
                            // x high bit set yet still on the line
                            2: put_sprite(s, 248, line - 12, 10'h1a3, 4'd7, 1'b0, 1'b1, later);
                            3: put_sprite(s, 328, line - 3, 10'h055, 4'd8, 1'b0, 1'b0, later);
                            4: put_sprite(s, 100, line + 1, 10'h066, 4'd9, 1'b0, 1'b0, later);
                            5: put_sprite(s, 140, line - 16, 10'h077, 4'd10, 1'b0, 1'b0, later);
                            6: put_sprite(s, 180, line - 15, 10'h388, 4'd11, 1'b1, 1'b1, later);
                            default: put_sprite(s, 394, line, 10'h099, 4'd12, 1'b0, 1'b0, later);
                        endcase
                    end
                    default: begin
                        r1 = lcg_next();
                        r2 = lcg_next();
                        // y biased so that most sprites touch the line
                        list_bytes[4*s]   = 8'd240 - 8'(line + 4 - r2[31:24] % 24);
                        list_bytes[4*s+1] = r1[15:8];
                        list_bytes[4*s+2] = r1[23:16];
                        list_bytes[4*s+3] = r1[31:24];
                    end
                endcase
            end
        end
    endtask

    // ======================================================================
    // reference model of one drawn line
    // ======================================================================
    task automatic build_expected(input logic later, input int line);
        logic [7:0] at;
        logic [9:0] tile;
        logic [3:0] colour;
        logic [3:0] fx;
        logic [3:0] fy;
        logic [3:0] pen;
        logic [7:0] bidx;
        logic [16:0] addr;
        logic [7:0] d;
        int         x;
        int         y;
        for (int h = 0; h < 256; h++) begin
            exp_line[h] = '0;
        end
        for (int s = 0; s < 64; s++) begin
            at = list_bytes[4*s+2];
            y  = (240 - list_bytes[4*s]) & 255;
            x  = ({at[0], list_bytes[4*s+3]} + 384) % 512;
            if (later) begin
                tile   = {at[1], at[4], list_bytes[4*s+1]};
                colour = {at[7:5], 1'b0};
            end else begin
                tile   = {1'b0, at[1], list_bytes[4*s+1]};
                colour = at[7:4];
            end
            if (x < 256 && line >= y && line - y < 16) begin
                for (int c = 0; c < 16 && x + c < 256; c++) begin
                    fx = at[2] ? 4'(15 - c) : 4'(c);
                    fy = at[3] ? 4'(15 - (line - y)) : 4'(line - y);
                    if (later) begin
                        addr = {fx[1], tile, fy, fx[3:2]};
                        bidx = {tile[9], tile[7:2], tile[8]};
                    end else begin
                        addr = {1'b0, fx[1], tile[8:0], fy, fx[3:2]};
                        bidx = tile[8:1];
                    end
                    d   = rom_byte(addr);
                    pen = fx[0] ? d[7:4] : d[3:0];
                    if (pen != (later ? 4'd15 : 4'd0)) begin
                        exp_line[x+c] = {bank_model[bidx], colour, pen};
                    end
                end
            end
        end
    endtask

    // ======================================================================
    // bus drivers
    // ======================================================================
    task automatic load_bank_prom();
        logic [31:0] r;
        for (int a = 0; a < 256; a++) begin
            r = lcg_next();
            bank_model[a] = r[27:24];
            @(negedge clk_sys);
            bank_wr   = 1'b1;
            bank_addr = 8'(a);
            bank_data = r[27:24];
        end
        @(negedge clk_sys);
        bank_wr = 1'b0;
    endtask

    task automatic write_list();
        for (int a = 0; a < 256; a++) begin
            @(negedge clk_sys);
            list_wr   = 1'b1;
            list_addr = 8'(a);
            list_data = list_bytes[a];
        end
        @(negedge clk_sys);
        list_wr = 1'b0;
    endtask

    // readout is one clock behind hpos
    task automatic sweep_line(input int t);
        @(negedge clk_sys);
        hpos = 9'd0;
        for (int h = 0; h < 256; h++) begin
            @(negedge clk_sys);
            check_value(sprite_pix, exp_line[h], $sformatf("test %0d pixel x %0d", t, h));
            if (h < 255) begin
                hpos = 9'(h + 1);
            end
        end
    endtask

    task automatic run_row(input int t);
        row_t row;
        int   line;
        row         = rows[t];
        line        = row.vpos + 1;
        test_errors = 0;
        @(negedge clk_sys);
        board_later = row.later;
        build_list(row.mode, row.count, row.later, line);
        write_list();
        build_expected(row.later, line);
        vblank = 1'b1;
        repeat (3) @(negedge clk_sys);
        vblank = 1'b0;
        wait_level(0, 1'b1, 20, "copy start");
        wait_level(0, 1'b0, 600, "copy end");
        if (!timed_out) begin
            @(negedge clk_sys);
            vpos = row.vpos;
            hpos = 9'd256;
        end
        wait_level(1, 1'b1, 10, "line draw start");
        wait_level(1, 1'b0, 4000, "line draw end");
        if (!timed_out) begin
            sweep_line(t);
        end
        $display("test %0d: %s board, %0d sprites, line %0d, %0d errors", t,
                 row.later ? "later" : "original", row.count, line, test_errors);
    endtask

    task automatic load_table();
        rows[0]  = '{1'b0, 7'd1,  MODE_SINGLE,  9'd99};
        rows[1]  = '{1'b0, 7'd4,  MODE_FLIP,    9'd150};
        rows[2]  = '{1'b1, 7'd4,  MODE_FLIP,    9'd150};
        rows[3]  = '{1'b0, 7'd6,  MODE_OVERLAP, 9'd60};
        rows[4]  = '{1'b1, 7'd6,  MODE_OVERLAP, 9'd61};
        rows[5]  = '{1'b0, 7'd8,  MODE_EDGE,    9'd200};
        rows[6]  = '{1'b1, 7'd8,  MODE_EDGE,    9'd30};
        rows[7]  = '{1'b1, 7'd64, MODE_LCG,     9'd15};
        rows[8]  = '{1'b1, 7'd64, MODE_LCG,     9'd120};
        rows[9]  = '{1'b0, 7'd64, MODE_LCG,     9'd230};
        rows[10] = '{1'b1, 7'd64, MODE_LCG,     9'd254};
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        reset       = 1'b1;
        list_wr     = 1'b0;
        list_addr   = '0;
        list_data   = '0;
        bank_wr     = 1'b0;
        bank_addr   = '0;
        bank_data   = '0;
        board_later = 1'b0;
        vblank      = 1'b0;
        hpos        = '0;
        vpos        = '0;
        lcg_state   = 32'h4857_162c;
        errors      = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        load_table();
        repeat (5) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        check_value(copy_busy, 1'b0, "copy_busy after reset");
        check_value(line_busy, 1'b0, "line_busy after reset");
        load_bank_prom();
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (!timed_out) begin
                run_row(t);
            end
        end
        $display("tests run %0d, errors %0d, timeout %0d", NUM_TESTS, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
